// ==== files.f ====
+incdir+include
rtl/dem_uart_pkg.sv
rtl/uart_bus_if.sv
rtl/dem_uart_fifo.sv
rtl/dem_uart_emul.sv
rtl/uart_16550.sv
rtl/dem_uart_bb.sv
tb/tb_dem_uart_bb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dem_uart_bb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qF "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/tb_dem_uart_bb.sv ====
`include "dem_uart_macros.svh"

module tb_dem_uart_bb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int DW = 32;
  localparam logic [15:0] MOD_ID = 16'h0012;
  // number of characters sent over all tests
  // the watchdog scales with it
  localparam int N_CHARS = 39;

  logic          clk;
  logic          rst_i;
  logic [15:0]   debug_in_data_i;
  logic          debug_in_valid_i;
  logic          debug_in_last_i;
  logic          debug_in_ready_o;
  logic [15:0]   debug_out_data_o;
  logic          debug_out_valid_o;
  logic          debug_out_last_o;
  logic          debug_out_ready_i;
  logic          irq_o;
  logic [3:0]    bb_addr_i;
  logic [DW-1:0] bb_din_i;
  logic          bb_en_i;
  logic          bb_we_i;
  logic [DW-1:0] bb_dout_o;

  // captured output flits as {last, data}
  logic [16:0] out_flits [$];
  // characters written to THR in write order
  logic [7:0]  exp_chars [$];
  int          errors;
  int          checks;
  int          tests;
  int          pkts_checked;
  // random back-pressure on the output flit stream
  logic        bp_en;

  dem_uart_bb #(.DW(DW)) dut0 (
    .clk               (clk),
    .rst_i             (rst_i),
    .id_i              (MOD_ID),
    .debug_in_data_i   (debug_in_data_i),
    .debug_in_valid_i  (debug_in_valid_i),
    .debug_in_last_i   (debug_in_last_i),
    .debug_in_ready_o  (debug_in_ready_o),
    .debug_out_data_o  (debug_out_data_o),
    .debug_out_valid_o (debug_out_valid_o),
    .debug_out_last_o  (debug_out_last_o),
    .debug_out_ready_i (debug_out_ready_i),
    .irq_o             (irq_o),
    .bb_addr_i         (bb_addr_i),
    .bb_din_i          (bb_din_i),
    .bb_en_i           (bb_en_i),
    .bb_we_i           (bb_we_i),
    .bb_dout_o         (bb_dout_o)
  );

  always #5 clk = ~clk;

  // event packet for a character with host, source id, type 2 and the char in the low byte
  // flit i sits at bits 16*i
  function automatic logic [63:0] expected_event_flits(input logic [7:0] ch,
                                                       input logic [15:0] id);
    return {8'h00, ch, 16'd2, id, `DEM_UART_HOST_ID};
  endfunction

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                             input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0d ns: %s, got %0h expected %0h", $time, msg, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int start);
    tests++;
    if (errors == start) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - start);
    end
  endtask

  // one strobe cycle followed by an idle cycle
  task automatic bus_write(input logic [2:0] addr, input logic [7:0] data);
    @(posedge clk);
    #1;
    bb_en_i   = 1'b1;
    bb_we_i   = 1'b1;
    bb_addr_i = {1'b0, addr};
    bb_din_i  = {{(DW - 8){1'b0}}, data};
    @(posedge clk);
    #1;
    bb_en_i = 1'b0;
    bb_we_i = 1'b0;
  endtask

  // read data is registered and sampled just after the edge that takes the strobe
  task automatic bus_read(input logic [2:0] addr, output logic [DW-1:0] data);
    @(posedge clk);
    #1;
    bb_en_i   = 1'b1;
    bb_we_i   = 1'b0;
    bb_addr_i = {1'b0, addr};
    @(posedge clk);
    #1;
    bb_en_i = 1'b0;
    data    = bb_dout_o;
  endtask

  // host sends four flits back to back
  task automatic send_packet(input logic [15:0] dest, input logic [15:0] ptype,
                             input logic [7:0] ch);
    logic [15:0] flits [4];
    flits[0] = dest;
    flits[1] = `DEM_UART_HOST_ID;
    flits[2] = ptype;
    flits[3] = {8'h00, ch};
    @(posedge clk);
    #1;
    for (int i = 0; i < 4; i++) begin
      debug_in_valid_i = 1'b1;
      debug_in_data_i  = flits[i];
      debug_in_last_i  = (i == 3);
      do @(negedge clk); while (!debug_in_ready_o);
      @(posedge clk);
      #1;
    end
    debug_in_valid_i = 1'b0;
    debug_in_last_i  = 1'b0;
  endtask

  // LSR polled a bounded number of times
  task automatic poll_data_ready(input string name);
    logic [DW-1:0] lsr;
    int            tries;
    tries = 0;
    lsr   = '0;
    while (!lsr[0] && tries < 8) begin
      bus_read(`DEM_UART_REG_LSR, lsr);
      tries++;
    end
    if (!lsr[0]) begin
      errors++;
      $display("%s: LSR data-ready never came up after a valid packet", name);
    end
  endtask

  // a flit moves on the edge that follows a negedge seeing valid and ready
  always @(negedge clk) begin
    if (!rst_i && debug_out_valid_o && debug_out_ready_i) begin
      out_flits.push_back({debug_out_last_o, debug_out_data_o});
    end
  end

  always @(posedge clk) begin
    #1;
    debug_out_ready_i = bp_en ? ($urandom % 2 == 1) : 1'b1;
  end

  // scoreboard checks one full packet at a time against the reference
  initial begin
    logic [16:0] flit;
    logic [63:0] exp_pkt;
    logic [7:0]  ch;
    forever begin
      @(posedge clk);
      while (out_flits.size() >= 4) begin
        ch = 8'h00;
        if (exp_chars.size() == 0) begin
          errors++;
          $display("event packet arrived with no character written to THR");
        end else begin
          ch = exp_chars.pop_front();
        end
        exp_pkt = expected_event_flits(ch, MOD_ID);
        for (int i = 0; i < 4; i++) begin
          flit = out_flits.pop_front();
          check_equal(flit[15:0], exp_pkt[16*i +: 16],
                      $sformatf("packet %0d flit %0d data", pkts_checked, i));
          check_equal(flit[16], i == 3,
                      $sformatf("packet %0d flit %0d last", pkts_checked, i));
        end
        pkts_checked++;
      end
    end
  end

  initial begin
    repeat (400 * N_CHARS + 2000) @(posedge clk);
    $display("timeout: run still busy after %0d cycles", 400 * N_CHARS + 2000);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    logic [DW-1:0] rd;
    logic [7:0]    ch;
    logic [7:0]    sent [$];
    int            start;
    int            waited;
    void'($urandom(32'h117f8702));
    clk = 1'b0;
    rst_i = 1'b1;
    debug_in_data_i = '0;
    debug_in_valid_i = 1'b0;
    debug_in_last_i = 1'b0;
    debug_out_ready_i = 1'b1;
    bb_addr_i = '0;
    bb_din_i = '0;
    bb_en_i = 1'b0;
    bb_we_i = 1'b0;
    bp_en = 1'b0;
    errors = 0;
    checks = 0;
    tests = 0;
    pkts_checked = 0;
    repeat (3) @(posedge clk);
    #1;
    rst_i = 1'b0;

    // reset values and scratch register
    start = errors;
    @(negedge clk);
    check_equal(irq_o, 1'b0, "irq_o after reset");
    check_equal(debug_out_valid_o, 1'b0, "debug_out_valid_o after reset");
    check_equal(debug_in_ready_o, 1'b1, "debug_in_ready_o after reset");
    bus_read(`DEM_UART_REG_LSR, rd);
    check_equal(rd[7:0], 8'h60, "LSR after reset");
    bus_read(`DEM_UART_REG_IIR, rd);
    check_equal(rd[7:0], 8'h01, "IIR after reset");
    bus_read(`DEM_UART_REG_IER, rd);
    check_equal(rd[7:0], 8'h00, "IER after reset");
    ch = 8'($urandom);
    bus_write(`DEM_UART_REG_SCR, ch);
    bus_read(`DEM_UART_REG_SCR, rd);
    check_equal(rd, {(DW / 8){ch}}, "SCR readback on every byte lane");
    report_test("reset", start);

    // ten THR writes under random back-pressure
    start = errors;
    bp_en = 1'b1;
    repeat (10) begin
      ch = 8'($urandom);
      exp_chars.push_back(ch);
      bus_write(`DEM_UART_REG_RBR, ch);
    end
    waited = 0;
    while (pkts_checked < 10 && waited < 4000) begin
      @(posedge clk);
      waited++;
    end
    if (pkts_checked < 10) begin
      errors++;
      $display("transmit: only %0d of 10 event packets arrived", pkts_checked);
    end
    bp_en = 1'b0;
    bus_read(`DEM_UART_REG_LSR, rd);
    check_equal(rd[7:0], 8'h60, "LSR once transmit FIFO drained");
    report_test("transmit", start);

    // write packets come back through RBR in order
    start = errors;
    sent.delete();
    repeat (5) begin
      ch = 8'($urandom);
      sent.push_back(ch);
      send_packet(MOD_ID, 16'd1, ch);
    end
    poll_data_ready("receive");
    foreach (sent[i]) begin
      bus_read(`DEM_UART_REG_RBR, rd);
      check_equal(rd[7:0], sent[i], $sformatf("receive RBR char %0d", i));
    end
    bus_read(`DEM_UART_REG_LSR, rd);
    check_equal(rd[0], 1'b0, "LSR data-ready after receive drain");
    report_test("receive", start);

    // foreign destination and unknown type are both dropped
    start = errors;
    send_packet(MOD_ID + 16'd1, 16'd1, 8'h41);
    send_packet(MOD_ID, 16'h0007, 8'h42);
    repeat (4) @(posedge clk);
    bus_read(`DEM_UART_REG_LSR, rd);
    check_equal(rd[0], 1'b0, "LSR data-ready after foreign packets");
    ch = 8'($urandom);
    send_packet(MOD_ID, 16'd1, ch);
    poll_data_ready("filter");
    bus_read(`DEM_UART_REG_RBR, rd);
    check_equal(rd[7:0], ch, "RBR after foreign packets");
    report_test("filter", start);

    // twenty characters into a sixteen entry FIFO
    start = errors;
    sent.delete();
    repeat (20) begin
      ch = 8'($urandom);
      sent.push_back(ch);
      send_packet(MOD_ID, 16'd1, ch);
    end
    repeat (4) @(posedge clk);
    bus_read(`DEM_UART_REG_LSR, rd);
    check_equal(rd[1:0], 2'b11, "LSR overrun and data-ready after overflow");
    bus_read(`DEM_UART_REG_LSR, rd);
    check_equal(rd[1], 1'b0, "LSR overrun cleared by the previous read");
    for (int i = 0; i < 16; i++) begin
      bus_read(`DEM_UART_REG_RBR, rd);
      check_equal(rd[7:0], sent[i], $sformatf("overflow RBR char %0d", i));
    end
    bus_read(`DEM_UART_REG_LSR, rd);
    check_equal(rd[0], 1'b0, "LSR data-ready after overflow drain");
    report_test("overflow", start);

    // received data interrupt followed by THR empty and then none
    start = errors;
    bus_write(`DEM_UART_REG_IER, 8'h01);
    @(negedge clk);
    check_equal(irq_o, 1'b0, "irq_o with IER 0x01 and no data");
    ch = 8'($urandom);
    send_packet(MOD_ID, 16'd1, ch);
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!irq_o && waited < 10);
    check_equal(irq_o, 1'b1, "irq_o on received data");
    bus_read(`DEM_UART_REG_IIR, rd);
    check_equal(rd[7:0], 8'h04, "IIR on received data");
    bus_read(`DEM_UART_REG_RBR, rd);
    check_equal(rd[7:0], ch, "RBR in interrupt test");
    bus_write(`DEM_UART_REG_IER, 8'h02);
    @(negedge clk);
    check_equal(irq_o, 1'b1, "irq_o on THR empty");
    bus_read(`DEM_UART_REG_IIR, rd);
    check_equal(rd[7:0], 8'h02, "IIR on THR empty");
    bus_write(`DEM_UART_REG_IER, 8'h00);
    @(negedge clk);
    check_equal(irq_o, 1'b0, "irq_o with IER 0");
    report_test("interrupts", start);

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== rtl/dem_uart_bb.sv ====
`include "dem_uart_macros.svh"

// bus-bridge wrapper around the UART emulation
module dem_uart_bb #(
  parameter int DW = `DEM_UART_BB_DW
) (
  input  logic                     clk,
  input  logic                     rst_i,
  input  dem_uart_pkg::dbg_id_t    id_i,
  input  dem_uart_pkg::flit_data_t debug_in_data_i,
  input  logic                     debug_in_valid_i,
  input  logic                     debug_in_last_i,
  output logic                     debug_in_ready_o,
  output dem_uart_pkg::flit_data_t debug_out_data_o,
  output logic                     debug_out_valid_o,
  output logic                     debug_out_last_o,
  input  logic                     debug_out_ready_i,
  output logic                     irq_o,
  // bit 3 of the address is not decoded
  input  logic [3:0]               bb_addr_i,
  input  logic [DW-1:0]            bb_din_i,
  input  logic                     bb_en_i,
  input  logic                     bb_we_i,
  output logic [DW-1:0]            bb_dout_o
);

  logic                     out_valid;
  dem_uart_pkg::uart_char_t out_char;
  logic                     out_ready;
  logic                     in_valid;
  dem_uart_pkg::uart_char_t in_char;
  logic                     in_ready;
  logic                     drop;

  uart_bus_if u_bus ();

  // bridge strobes map one to one onto the register bus
  assign u_bus.req   = bb_en_i;
  assign u_bus.addr  = bb_addr_i[2:0];
  assign u_bus.write = bb_we_i;
  assign u_bus.wdata = bb_din_i[7:0];

  // same byte on every lane
  assign bb_dout_o = {(DW / 8){u_bus.rdata}};

  dem_uart_emul u_uart_emul (
    .clk               (clk),
    .rst_i             (rst_i),
    .id_i              (id_i),
    .debug_in_data_i   (debug_in_data_i),
    .debug_in_valid_i  (debug_in_valid_i),
    .debug_in_last_i   (debug_in_last_i),
    .debug_in_ready_o  (debug_in_ready_o),
    .debug_out_data_o  (debug_out_data_o),
    .debug_out_valid_o (debug_out_valid_o),
    .debug_out_last_o  (debug_out_last_o),
    .debug_out_ready_i (debug_out_ready_i),
    .out_valid_i       (out_valid),
    .out_char_i        (out_char),
    .out_ready_o       (out_ready),
    .in_valid_o        (in_valid),
    .in_char_o         (in_char),
    .in_ready_i        (in_ready),
    .drop_i            (drop)
  );

  uart_16550 u_16550 (
    .clk         (clk),
    .rst_i       (rst_i),
    .bus         (u_bus.slave),
    .out_valid_o (out_valid),
    .out_char_o  (out_char),
    .out_ready_i (out_ready),
    .in_valid_i  (in_valid),
    .in_char_i   (in_char),
    .in_ready_o  (in_ready),
    .drop_o      (drop),
    .irq_o       (irq_o)
  );

endmodule

// ==== rtl/uart_16550.sv ====
`include "dem_uart_macros.svh"

// 16550-style register file with character FIFOs and no baud generator
module uart_16550 (
  input  logic                     clk,
  input  logic                     rst_i,
  uart_bus_if.slave                bus,
  // transmit characters towards the packet engine
  output logic                     out_valid_o,
  output dem_uart_pkg::uart_char_t out_char_o,
  input  logic                     out_ready_i,
  // received characters from the packet engine
  input  logic                     in_valid_i,
  input  dem_uart_pkg::uart_char_t in_char_i,
  output logic                     in_ready_o,
  output logic                     drop_o,
  output logic                     irq_o
);

  logic [1:0]               ier;
  dem_uart_pkg::uart_char_t lcr;
  dem_uart_pkg::uart_char_t mcr;
  dem_uart_pkg::uart_char_t scr;
  logic                     overrun;
  logic                     wr_en;
  logic                     rd_en;
  logic                     tx_empty;
  logic                     rx_empty;
  logic                     rx_full;
  logic                     data_ready;
  dem_uart_pkg::uart_char_t rx_char;
  dem_uart_pkg::uart_char_t lsr;
  dem_uart_pkg::uart_char_t iir;
  dem_uart_pkg::uart_char_t rd_byte;

  assign wr_en = bus.req && bus.write;
  assign rd_en = bus.req && !bus.write;

  // THR writes go straight in and the FIFO drops them once full
  dem_uart_fifo #(.DEPTH(`DEM_UART_FIFO_DEPTH)) tx_fifo (
    .clk     (clk),
    .rst_i   (rst_i),
    .push_i  (wr_en && bus.addr == `DEM_UART_REG_RBR),
    .data_i  (bus.wdata),
    .pop_i   (out_ready_i),
    .data_o  (out_char_o),
    .empty_o (tx_empty),
    .full_o  ()
  );

  // RBR read pops in the access cycle
  dem_uart_fifo #(.DEPTH(`DEM_UART_FIFO_DEPTH)) rx_fifo (
    .clk     (clk),
    .rst_i   (rst_i),
    .push_i  (in_valid_i),
    .data_i  (in_char_i),
    .pop_i   (rd_en && bus.addr == `DEM_UART_REG_RBR),
    .data_o  (rx_char),
    .empty_o (rx_empty),
    .full_o  (rx_full)
  );

  assign out_valid_o = !tx_empty;
  assign in_ready_o  = !rx_full;
  // a full receive FIFO tells the engine not to wait
  assign drop_o      = rx_full;
  assign data_ready  = !rx_empty;

  // bits 5 and 6 both track an empty transmit FIFO since nothing shifts out here
  assign lsr = {1'b0, tx_empty, tx_empty, 3'b000, overrun, data_ready};

  // received data outranks THR empty
  always_comb begin
    if (ier[0] && data_ready) begin
      iir = 8'h04;
    end else if (ier[1] && tx_empty) begin
      iir = 8'h02;
    end else begin
      iir = 8'h01;
    end
  end

  assign irq_o = (ier[0] && data_ready) || (ier[1] && tx_empty);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ier     <= '0;
      lcr     <= '0;
      mcr     <= '0;
      scr     <= '0;
      overrun <= 1'b0;
    end else begin
      if (wr_en) begin
        case (bus.addr)
          `DEM_UART_REG_IER: ier <= bus.wdata[1:0];
          `DEM_UART_REG_LCR: lcr <= bus.wdata;
          `DEM_UART_REG_MCR: mcr <= bus.wdata;
          `DEM_UART_REG_SCR: scr <= bus.wdata;
          default: ;
        endcase
      end
      // a new overrun wins over a clearing LSR read
      if (in_valid_i && rx_full) begin
        overrun <= 1'b1;
      end else if (rd_en && bus.addr == `DEM_UART_REG_LSR) begin
        overrun <= 1'b0;
      end
    end
  end

  always_comb begin
    case (bus.addr)
      `DEM_UART_REG_RBR: rd_byte = rx_char;
      `DEM_UART_REG_IER: rd_byte = {6'b0, ier};
      `DEM_UART_REG_IIR: rd_byte = iir;
      `DEM_UART_REG_LCR: rd_byte = lcr;
      `DEM_UART_REG_MCR: rd_byte = mcr;
      `DEM_UART_REG_LSR: rd_byte = lsr;
      // no modem lines
      `DEM_UART_REG_MSR: rd_byte = 8'h00;
      default:           rd_byte = scr;
    endcase
  end

  // read data shows up one cycle after the strobe
  always_ff @(posedge clk) begin
    if (rd_en) begin
      bus.rdata <= rd_byte;
    end
  end

endmodule

// ==== rtl/dem_uart_emul.sv ====
`include "dem_uart_macros.svh"

// packet engine between the character streams and the debug flit network
module dem_uart_emul (
  input  logic                     clk,
  input  logic                     rst_i,
  input  dem_uart_pkg::dbg_id_t    id_i,
  // flits from the host
  input  dem_uart_pkg::flit_data_t debug_in_data_i,
  input  logic                     debug_in_valid_i,
  input  logic                     debug_in_last_i,
  output logic                     debug_in_ready_o,
  // flits to the host
  output dem_uart_pkg::flit_data_t debug_out_data_o,
  output logic                     debug_out_valid_o,
  output logic                     debug_out_last_o,
  input  logic                     debug_out_ready_i,
  // characters written by the cpu
  input  logic                     out_valid_i,
  input  dem_uart_pkg::uart_char_t out_char_i,
  output logic                     out_ready_o,
  // characters for the receive FIFO
  output logic                     in_valid_o,
  output dem_uart_pkg::uart_char_t in_char_o,
  input  logic                     in_ready_i,
  input  logic                     drop_i
);

  dem_uart_pkg::tx_state_e  tx_state;
  dem_uart_pkg::rx_state_e  rx_state;
  dem_uart_pkg::uart_char_t tx_char;
  logic                     tx_fire;
  logic                     rx_fire;

  assign tx_fire = debug_out_valid_o && debug_out_ready_i;
  assign rx_fire = debug_in_valid_i && debug_in_ready_o;

  // header flit waits on a character, the rest go out back to back
  assign debug_out_valid_o = (tx_state == dem_uart_pkg::TX_DEST) ? out_valid_i : 1'b1;
  assign debug_out_last_o  = (tx_state == dem_uart_pkg::TX_PAYLOAD);
  // pop the FIFO as the destination flit leaves
  assign out_ready_o = (tx_state == dem_uart_pkg::TX_DEST) && debug_out_ready_i;

  always_comb begin
    case (tx_state)
      dem_uart_pkg::TX_DEST:   debug_out_data_o = `DEM_UART_HOST_ID;
      dem_uart_pkg::TX_SRC:    debug_out_data_o = id_i;
      dem_uart_pkg::TX_TYPE:   debug_out_data_o = dem_uart_pkg::PKT_CHAR_EVENT;
      default:                 debug_out_data_o = {8'h00, tx_char};
    endcase
  end

  // character held for the payload flit
  always_ff @(posedge clk) begin
    if (tx_state == dem_uart_pkg::TX_DEST && tx_fire) begin
      tx_char <= out_char_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      tx_state <= dem_uart_pkg::TX_DEST;
    end else if (tx_fire) begin
      case (tx_state)
        dem_uart_pkg::TX_DEST: tx_state <= dem_uart_pkg::TX_SRC;
        dem_uart_pkg::TX_SRC:  tx_state <= dem_uart_pkg::TX_TYPE;
        dem_uart_pkg::TX_TYPE: tx_state <= dem_uart_pkg::TX_PAYLOAD;
        default:               tx_state <= dem_uart_pkg::TX_DEST;
      endcase
    end
  end

  // never back-pressure the debug network
  assign debug_in_ready_o = 1'b1;

  always_ff @(posedge clk) begin
    if (rx_fire && rx_state == dem_uart_pkg::RX_PAYLOAD) begin
      in_char_o <= debug_in_data_i[7:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      rx_state   <= dem_uart_pkg::RX_DEST;
      in_valid_o <= 1'b0;
    end else begin
      // strobe ends when taken, or when the register side is dropping
      if (in_valid_o && (in_ready_i || drop_i)) begin
        in_valid_o <= 1'b0;
      end
      if (rx_fire) begin
        case (rx_state)
          dem_uart_pkg::RX_DEST: begin
            if (debug_in_last_i) begin
              rx_state <= dem_uart_pkg::RX_DEST;
            end else if (debug_in_data_i == id_i) begin
              rx_state <= dem_uart_pkg::RX_SRC;
            end else begin
              rx_state <= dem_uart_pkg::RX_DISCARD;
            end
          end
          dem_uart_pkg::RX_SRC: begin
            // source id is not checked
            rx_state <= debug_in_last_i ? dem_uart_pkg::RX_DEST : dem_uart_pkg::RX_TYPE;
          end
          dem_uart_pkg::RX_TYPE: begin
            if (debug_in_last_i) begin
              rx_state <= dem_uart_pkg::RX_DEST;
            end else if (debug_in_data_i == dem_uart_pkg::PKT_CHAR_WRITE) begin
              rx_state <= dem_uart_pkg::RX_PAYLOAD;
            end else begin
              rx_state <= dem_uart_pkg::RX_DISCARD;
            end
          end
          dem_uart_pkg::RX_PAYLOAD: begin
            in_valid_o <= 1'b1;
            // overlong packets are eaten up to last
            rx_state <= debug_in_last_i ? dem_uart_pkg::RX_DEST : dem_uart_pkg::RX_DISCARD;
          end
          default: begin
            if (debug_in_last_i) begin
              rx_state <= dem_uart_pkg::RX_DEST;
            end
          end
        endcase
      end
    end
  end

endmodule

// ==== rtl/dem_uart_fifo.sv ====
// first-word-fall-through character FIFO
module dem_uart_fifo #(
  parameter int DEPTH = 16
) (
  input  logic                     clk,
  input  logic                     rst_i,
  input  logic                     push_i,
  input  dem_uart_pkg::uart_char_t data_i,
  input  logic                     pop_i,
  output dem_uart_pkg::uart_char_t data_o,
  output logic                     empty_o,
  output logic                     full_o
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  dem_uart_pkg::uart_char_t mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          do_push;
  logic          do_pop;

  // overflow and underflow requests are dropped here
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign empty_o = (count == '0);
  assign full_o  = (count == CW'(DEPTH));
  // head entry is always on the output
  assign data_o  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap at DEPTH, not at the power of two
      if (do_push) begin
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== rtl/uart_bus_if.sv ====
// byte wide register bus between the bridge and the 16550 block
interface uart_bus_if;

  // access strobe, one cycle per access
  logic                   req;
  dem_uart_pkg::reg_addr_t  addr;
  // high for a register write
  logic                   write;
  dem_uart_pkg::uart_char_t wdata;
  // registered, valid the cycle after req
  dem_uart_pkg::uart_char_t rdata;

  // bridge side
  modport master (output req, output addr, output write, output wdata, input rdata);

  // register block side
  modport slave (input req, input addr, input write, input wdata, output rdata);

endinterface

// ==== rtl/dem_uart_pkg.sv ====
`include "dem_uart_macros.svh"

package dem_uart_pkg;

  // one debug flit
  typedef logic [`DEM_UART_FLIT_W-1:0] flit_data_t;
  // module or host address on the debug network
  typedef logic [15:0] dbg_id_t;
  // one UART character
  typedef logic [7:0] uart_char_t;
  // byte register offset
  typedef logic [2:0] reg_addr_t;

  // third flit of every packet
  typedef enum logic [15:0] {
    PKT_CHAR_WRITE = 16'd1,
    PKT_CHAR_EVENT = 16'd2
  } pkt_type_e;

  // transmit side walks the four flits of an event packet
  typedef enum logic [1:0] {TX_DEST, TX_SRC, TX_TYPE, TX_PAYLOAD} tx_state_e;

  // receive side, discard eats the rest of a foreign packet
  typedef enum logic [2:0] {
    RX_DEST, RX_SRC, RX_TYPE, RX_PAYLOAD, RX_DISCARD
  } rx_state_e;

endpackage

// ==== include/dem_uart_macros.svh ====
`ifndef DEM_UART_MACROS_SVH
`define DEM_UART_MACROS_SVH

// debug flit payload width
`define DEM_UART_FLIT_W 16
// entries in each character FIFO
`define DEM_UART_FIFO_DEPTH 16
// event packets always go to the host
`define DEM_UART_HOST_ID 16'h0000
// default bus-bridge data width
`define DEM_UART_BB_DW 32

// 16550 register map, THR shares offset 0 with RBR
`define DEM_UART_REG_RBR 3'd0
`define DEM_UART_REG_IER 3'd1
`define DEM_UART_REG_IIR 3'd2
`define DEM_UART_REG_LCR 3'd3
`define DEM_UART_REG_MCR 3'd4
`define DEM_UART_REG_LSR 3'd5
`define DEM_UART_REG_MSR 3'd6
`define DEM_UART_REG_SCR 3'd7

`endif
